// File: all.f
+incdir+design
+incdir+tests
design/main_bus_pkg.sv
design/main_ctrl_pkg.sv
design/main_bus_if.sv
design/bus_arbiter.sv
design/main_decoder.sv
design/work_ram.sv
design/irq_gen.sv
design/main_top.sv
tests/tb_main.sv

// File: Makefile
# Verilator build and run of the main bus board testbench

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_main -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_main); echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: tests/tb_main_tasks.svh
// Reference model of the bus-visible state
data_t      ram_model [RAM_WORDS];
data_t      scrl_model [4] = '{default: '0};
logic       flip_m = 1'b0;
logic       bank_m = 1'b0;
logic [7:0] latch_m;
int         nmi_exp = 0;  // Offset-1 writes with the upper strobe
bit         busy [2];     // Transaction open on the port, 1 is the MCU

// Bit 1 of be is the upper byte
function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
    data_t res;
    res = old;
    if (be[1]) res[15:8] = wdata[15:8];
    if (be[0]) res[7:0]  = wdata[7:0];
    return res;
endfunction

function automatic addr_t ram_addr(input int w);
    return {3'b111, 13'(w)};
endfunction

// Coins, starts, then both sticks with the two buttons swapped
function automatic data_t cabinet_word();
    data_t w;
    w[15]   = coin_input[0];
    w[14]   = coin_input[1];
    w[13]   = start_button[0];
    w[12]   = start_button[1];
    w[11:8] = joystick1[3:0];
    w[7]    = joystick1[4];
    w[6]    = joystick1[5];
    w[5:2]  = joystick2[3:0];
    w[1]    = joystick2[4];
    w[0]    = joystick2[5];
    return w;
endfunction

task automatic check(input string name, input data_t exp, input data_t got);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("Error %s: expected %h, actual %h at %0t", name, exp, got, $time);
    end
endtask

task automatic idle(input int n);
    repeat (n) begin
        @(posedge clk);
        #1;
    end
endtask

task automatic drive_master(input bit port, input bit req, input bit wr, input be_t be,
                            input addr_t addr, input data_t wdata);
    if (port) begin
        mcu_we    = wr;
        mcu_be    = be;
        mcu_addr  = addr;
        mcu_wdata = wdata;
        mcu_req   = req;
    end else begin
        cpu_we    = wr;
        cpu_be    = be;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_req   = req;
    end
endtask

//////////////////////////////////////////////////
// One four-phase transaction, port 1 is the MCU
task automatic bus_access(input bit port, input bit wr, input be_t be, input addr_t addr,
                          input data_t wdata, output data_t rdata, output int lat);
    int n;
    busy[port] = 1'b1;
    drive_master(port, 1'b1, wr, be, addr, wdata);
    n = 0;
    do begin
        @(posedge clk);
        #1;
        n++;
    end while (!(port ? mcu_ack : cpu_ack));
    lat   = n;
    rdata = port ? mcu_rdata : cpu_rdata;
    drive_master(port, 1'b0, wr, be, addr, wdata);
    n = 0;
    do begin
        @(posedge clk);
        #1;
        n++;
    end while (port ? mcu_ack : cpu_ack);
    busy[port] = 1'b0;
    check("ack release", 16'd1, data_t'(n));
endtask

// From an idle bus, so the ack latency is exact
task automatic timed_access(input bit port, input bit wr, input be_t be, input addr_t addr,
                            input data_t wdata, input int exp_lat, output data_t rdata);
    int lat;
    idle(2);
    bus_access(port, wr, be, addr, wdata, rdata, lat);
    check("ack latency", data_t'(exp_lat), data_t'(lat));
endtask

task automatic ram_traffic(input bit port, input int count);
    int    w;
    int    lat;
    bit    wr;
    be_t   be;
    data_t wdata;
    data_t rdata;
    repeat (count) begin
        idle($urandom % 4);
        w     = $urandom % RAM_WORDS;
        wr    = 1'($urandom);
        be    = be_t'($urandom);
        wdata = data_t'($urandom);
        bus_access(port, wr, be, ram_addr(w), wdata, rdata, lat);
        if (wr)
            ram_model[w] = merge_bytes(ram_model[w], wdata, be);
        else
            check("ram read", ram_model[w], rdata);
    end
endtask

// File: tests/tb_main.sv
`include "main_defines.svh"

module tb_main;
    import main_bus_pkg::*;

    localparam int RAM_WORDS = 64;  // Word pool shared by both ports
    localparam int N_RAND    = 150;  // Per port
    localparam int N_SCRL    = 40;
    localparam int N_IO      = 60;
    localparam int N_TRANS   = RAM_WORDS + 2 * N_RAND + 2 * N_SCRL + N_IO + 15;
    localparam int LIMIT     = N_TRANS * (`IO_WAIT + 8) + 200;

    logic       clk;
    logic       rst;
    logic       cpu_req, cpu_we, cpu_ack;
    be_t        cpu_be;
    addr_t      cpu_addr;
    data_t      cpu_wdata, cpu_rdata;
    logic       mcu_req, mcu_we, mcu_ack;
    be_t        mcu_be;
    addr_t      mcu_addr;
    data_t      mcu_wdata, mcu_rdata;
    logic [5:0] joystick1, joystick2;
    logic [1:0] start_button, coin_input;
    logic [7:0] dipsw_a, dipsw_b, snd_latch;
    logic       lvbl, v8, dip_pause, iack;
    logic       flip, scr_bank, snd_nmi, int1, int2;
    data_t      scr1_hpos, scr1_vpos;
    logic [8:0] scr2_hpos, scr2_vpos;
    int         errors = 0;
    int         checks = 0;
    int         nmi_seen = 0;

    main_top dut_i (.*);

    `include "tb_main_tasks.svh"

    always #4 clk = ~clk;

    // Ownership and sound NMI monitor
    always @(negedge clk) begin
        if (!rst) begin
            if (snd_nmi)
                nmi_seen++;  // One count per cycle high
            assert ((!cpu_ack || busy[0]) && (!mcu_ack || busy[1]) && !(cpu_ack && mcu_ack))
            else begin
                errors++;
                $display("Ack reached a port that does not own the bus at %0t", $time);
            end
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Watchdog: run still busy after %0d cycles, a transaction hung", LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        data_t rd;
        data_t rd_c;
        data_t wd;
        addr_t addr;
        be_t   be;
        bit    wr;
        bit    port;
        int    off;
        int    lat_c;
        int    lat_m;
        void'($urandom(32'h9a7f));
        clk = 1'b0;
        rst = 1'b1;
        drive_master(1'b0, 1'b0, 1'b0, 2'b00, '0, '0);
        drive_master(1'b1, 1'b0, 1'b0, 2'b00, '0, '0);
        joystick1    = '0;
        joystick2    = '0;
        start_button = '0;
        coin_input   = '0;
        dipsw_a      = '0;
        dipsw_b      = '0;
        lvbl      = 1'b1;
        v8        = 1'b0;
        dip_pause = 1'b1;  // Running
        iack      = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        checks++;
        assert ({cpu_ack, mcu_ack, snd_nmi, int1, int2, flip, scr_bank,
                 scr1_hpos, scr1_vpos, scr2_hpos, scr2_vpos} === '0)
        else begin
            errors++;
            $display("Outputs are not at their reset values after reset");
        end

        //////////////////////////////////////////////////
        // Work RAM, fill the pool then mixed traffic from both ports
        for (int w = 0; w < RAM_WORDS; w++) begin
            wd = data_t'($urandom);
            bus_access(1'(w), 1'b1, 2'b11, ram_addr(w), wd, rd, lat_c);
            ram_model[w] = wd;
        end
        fork
            ram_traffic(1'b0, N_RAND);
            ram_traffic(1'b1, N_RAND);
        join

        // Both request from idle
        idle(2);
        fork
            bus_access(1'b0, 1'b0, 2'b11, ram_addr(1), 16'h0, rd_c, lat_c);
            bus_access(1'b1, 1'b0, 2'b11, ram_addr(2), 16'h0, rd, lat_m);
        join
        check("ram read", ram_model[1], rd_c);
        check("ram read", ram_model[2], rd);
        check("mcu latency", 16'd2, data_t'(lat_m));
        checks++;
        assert (lat_c > lat_m) else begin
            errors++;
            $display("CPU was served before the MCU on simultaneous requests");
        end

        for (int i = 0; i < 4; i++) begin
            wd = data_t'($urandom);
            be = be_t'($urandom);
            timed_access(1'(i), 1'b1, be, ram_addr(i + 8), wd, 2, rd);
            ram_model[i + 8] = merge_bytes(ram_model[i + 8], wd, be);
            timed_access(!1'(i), 1'b0, 2'b11, ram_addr(i + 8), 16'h0, 2, rd);
            check("ram read", ram_model[i + 8], rd);
        end

        //////////////////////////////////////////////////
        // Scroll registers, layer 2 keeps 9 bits
        repeat (N_SCRL) begin
            off  = $urandom % 4;
            be   = be_t'($urandom);
            wd   = data_t'($urandom);
            port = 1'($urandom);
            addr = {3'b100, 11'($urandom), 2'(off)};
            timed_access(port, 1'b1, be, addr, wd, 2, rd);
            scrl_model[off] = merge_bytes(scrl_model[off], wd, be);
            if (off >= 2)
                scrl_model[off] &= 16'h01ff;
            timed_access(!port, 1'b0, 2'b11, addr, 16'h0, 2, rd);
            check("scroll read", scrl_model[off], rd);
            check("scroll 1 h", scrl_model[0], scr1_hpos);
            check("scroll 1 v", scrl_model[1], scr1_vpos);
            check("scroll 2 h", scrl_model[2], data_t'(scr2_hpos));
            check("scroll 2 v", scrl_model[3], data_t'(scr2_vpos));
        end

        // I/O with fresh cabinet inputs each time
        repeat (N_IO) begin
            joystick1    = 6'($urandom);
            joystick2    = 6'($urandom);
            start_button = 2'($urandom);
            coin_input   = 2'($urandom);
            dipsw_a      = 8'($urandom);
            dipsw_b      = 8'($urandom);
            off  = $urandom % 2;
            wr   = 1'($urandom);
            be   = be_t'($urandom);
            wd   = data_t'($urandom);
            addr = {3'b101, 12'($urandom), 1'(off)};
            timed_access(1'($urandom), wr, be, addr, wd, 2 + `IO_WAIT, rd);
            if (!wr)
                check("io read", off ? {dipsw_b, dipsw_a} : cabinet_word(), rd);
            else if (be[1] && off == 0) begin
                flip_m = wd[8];
                bank_m = wd[2];
            end else if (be[1]) begin
                latch_m = wd[7:0];
                nmi_exp++;
            end
            check("flip and bank", data_t'({flip_m, bank_m}), data_t'({flip, scr_bank}));
            if (nmi_exp > 0)
                check("sound latch", data_t'(latch_m), data_t'(snd_latch));
        end

        for (int r = 0; r < 8; r++) begin
            if (r inside {4, 5, 7})
                continue;  // Mapped regions
            timed_access(1'(r), 1'b0, 2'b11, {3'(r), 13'($urandom)}, 16'h0, 2, rd);
            check("unmapped read", 16'hffff, rd);
        end

        //////////////////////////////////////////////////
        // Interrupts
        idle(2);
        lvbl = 1'b0;
        v8   = 1'b1;
        check("irq before edge", 16'd0, data_t'({int1, int2}));
        idle(1);
        check("irq raise", 16'd3, data_t'({int1, int2}));
        iack = 1'b1;
        idle(1);
        check("irq clear", 16'd0, data_t'({int1, int2}));
        iack      = 1'b0;
        lvbl      = 1'b1;
        v8        = 1'b0;
        dip_pause = 1'b0;  // Paused
        idle(2);
        lvbl = 1'b0;
        v8   = 1'b1;
        idle(2);
        check("irq paused", 16'd0, data_t'({int1, int2}));
        dip_pause = 1'b1;
        lvbl      = 1'b1;
        idle(2);
        lvbl = 1'b0;
        iack = 1'b1;  // Same cycle as the edge
        idle(1);
        check("irq ack priority", 16'd0, data_t'({int1, int2}));
        iack = 1'b0;
        idle(2);

        check("sound NMI pulses", data_t'(nmi_exp), data_t'(nmi_seen));
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end
endmodule

// File: design/main_top.sv
module main_top (
    input  logic                clk,
    input  logic                rst,
    // 68000 bus master
    input  logic                cpu_req,
    input  logic                cpu_we,
    input  main_bus_pkg::be_t   cpu_be,
    input  main_bus_pkg::addr_t cpu_addr,
    input  main_bus_pkg::data_t cpu_wdata,
    output logic                cpu_ack,
    output main_bus_pkg::data_t cpu_rdata,
    // MCU DMA master
    input  logic                mcu_req,
    input  logic                mcu_we,
    input  main_bus_pkg::be_t   mcu_be,
    input  main_bus_pkg::addr_t mcu_addr,
    input  main_bus_pkg::data_t mcu_wdata,
    output logic                mcu_ack,
    output main_bus_pkg::data_t mcu_rdata,
    // Cabinet
    input  logic [5:0]          joystick1,
    input  logic [5:0]          joystick2,
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic [7:0]          dipsw_a,
    input  logic [7:0]          dipsw_b,
    // Video timing and interrupts
    input  logic                lvbl,
    input  logic                v8,
    input  logic                dip_pause,
    input  logic                iack,
    output logic                flip,
    output logic                scr_bank,
    output logic [7:0]          snd_latch,
    output logic                snd_nmi,
    output main_bus_pkg::data_t scr1_hpos,
    output main_bus_pkg::data_t scr1_vpos,
    output logic [8:0]          scr2_hpos,
    output logic [8:0]          scr2_vpos,
    output logic                int1,
    output logic                int2
);
    import main_bus_pkg::*;

    be_t       ram_we;
    ram_addr_t ram_addr;
    data_t     ram_wdata;
    data_t     ram_rdata;

    main_bus_if bus_if ();  // Arbiter to decoder

    bus_arbiter u_arbiter (.*, .bus(bus_if));

    main_decoder u_decoder (.*, .bus(bus_if));

    work_ram u_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    irq_gen u_irq (.*);
endmodule

// File: design/irq_gen.sv
module irq_gen (
    input  logic clk,
    input  logic rst,
    input  logic lvbl,       // Low during vertical blank
    input  logic v8,         // Line counter bit 8
    input  logic dip_pause,  // High means running
    input  logic iack,
    output logic int1,
    output logic int2
);
    logic lvbl_l;
    logic v8_l;
    logic vbl_fall;
    logic v8_rise;

    assign vbl_fall = lvbl_l && !lvbl;
    assign v8_rise  = v8 && !v8_l;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;
            v8_l   <= 1'b1;
            int1   <= 1'b0;
            int2   <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            v8_l   <= v8;
            // Acknowledge beats a new edge in the same cycle
            if (iack) begin
                int1 <= 1'b0;
                int2 <= 1'b0;
            end else if (dip_pause) begin
                if (vbl_fall) int1 <= 1'b1;
                if (v8_rise)  int2 <= 1'b1;  // Line 256
            end
        end
    end
endmodule

// File: design/work_ram.sv
`include "main_defines.svh"

module work_ram (
    input  logic                    clk,
    input  main_bus_pkg::be_t       we,
    input  main_bus_pkg::ram_addr_t addr,
    input  main_bus_pkg::data_t     wdata,
    output main_bus_pkg::data_t     rdata
);
    import main_bus_pkg::*;

    localparam int HALF = `MAIN_DW / 2;

    data_t mem [0:(1 << `RAM_AW) - 1];

    // Byte lanes written on their own
    always_ff @(posedge clk) begin
        if (we[1]) mem[addr][`MAIN_DW-1:HALF] <= wdata[`MAIN_DW-1:HALF];
        if (we[0]) mem[addr][HALF-1:0]        <= wdata[HALF-1:0];
        rdata <= mem[addr];  // Old word on a write cycle
    end
endmodule

// File: design/main_decoder.sv
`include "main_defines.svh"

module main_decoder (
    input  logic                    clk,
    input  logic                    rst,
    main_bus_if.slave               bus,
    // Work RAM
    output main_bus_pkg::be_t       ram_we,
    output main_bus_pkg::ram_addr_t ram_addr,
    output main_bus_pkg::data_t     ram_wdata,
    input  main_bus_pkg::data_t     ram_rdata,
    // Cabinet and DIP
    input  logic [5:0]              joystick1,
    input  logic [5:0]              joystick2,
    input  logic [1:0]              start_button,
    input  logic [1:0]              coin_input,
    input  logic [7:0]              dipsw_a,
    input  logic [7:0]              dipsw_b,
    // Special and scroll registers
    output logic                    flip,
    output logic                    scr_bank,
    output logic [7:0]              snd_latch,
    output logic                    snd_nmi,
    output main_bus_pkg::data_t     scr1_hpos,
    output main_bus_pkg::data_t     scr1_vpos,
    output logic [8:0]              scr2_hpos,
    output logic [8:0]              scr2_vpos
);
    import main_bus_pkg::*;
    import main_ctrl_pkg::*;

    localparam int CNT_W = $clog2(`IO_WAIT + 1);

    acc_state_e       state;
    logic [CNT_W-1:0] wait_cnt;
    region_e          region;
    logic             accept;  // Request taken this cycle
    logic             wr_up;
    logic             wr_lo;
    logic             io_up;   // Upper-lane I/O write

    always_comb begin
        case (bus.addr[`MAIN_AW-1 -: 3])
            3'd7:    region = RAM_R;
            3'd5:    region = IO_R;
            3'd4:    region = SCRL_R;
            default: region = NONE_R;
        endcase
    end

    assign accept = (state == WAIT_REQ) && bus.req;
    assign wr_up  = accept && bus.we && bus.be[1];
    assign wr_lo  = accept && bus.we && bus.be[0];
    assign io_up  = wr_up && (region == IO_R);

    //////////////////////////////////////////////////
    // Ack sequencer, I/O holds ack off like DTACK
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= WAIT_REQ;
            wait_cnt <= '0;
            bus.ack  <= 1'b0;
        end else begin
            case (state)
                WAIT_REQ: if (accept) begin
                    if (region == IO_R) begin
                        state    <= STRETCH;
                        wait_cnt <= CNT_W'(`IO_WAIT - 1);
                    end else begin
                        state   <= ACK_HI;
                        bus.ack <= 1'b1;
                    end
                end
                STRETCH: if (wait_cnt == '0) begin
                    state   <= ACK_HI;
                    bus.ack <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
                default: if (!bus.req) begin
                    state   <= WAIT_REQ;
                    bus.ack <= 1'b0;
                end
            endcase
        end
    end

    assign ram_addr  = bus.addr[`RAM_AW-1:0];
    assign ram_wdata = bus.wdata;
    assign ram_we    = {wr_up, wr_lo} & {2{region == RAM_R}};

    //////////////////////////////////////////////////
    // Scroll positions, layer 2 keeps 9 bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scr1_hpos <= '0;
            scr1_vpos <= '0;
            scr2_hpos <= '0;
            scr2_vpos <= '0;
        end else if (region == SCRL_R) begin
            case (bus.addr[1:0])
                2'd0: begin
                    if (wr_up) scr1_hpos[15:8] <= bus.wdata[15:8];
                    if (wr_lo) scr1_hpos[7:0]  <= bus.wdata[7:0];
                end
                2'd1: begin
                    if (wr_up) scr1_vpos[15:8] <= bus.wdata[15:8];
                    if (wr_lo) scr1_vpos[7:0]  <= bus.wdata[7:0];
                end
                2'd2: begin
                    if (wr_up) scr2_hpos[8]   <= bus.wdata[8];
                    if (wr_lo) scr2_hpos[7:0] <= bus.wdata[7:0];
                end
                default: begin
                    if (wr_up) scr2_vpos[8]   <= bus.wdata[8];
                    if (wr_lo) scr2_vpos[7:0] <= bus.wdata[7:0];
                end
            endcase
        end
    end

    // Special registers all qualify on the upper strobe, as on the PCB
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip     <= 1'b0;
            scr_bank <= 1'b0;
            snd_nmi  <= 1'b0;
        end else begin
            snd_nmi <= io_up && bus.addr[0];  // One-cycle pulse
            if (io_up && !bus.addr[0]) begin
                flip     <= bus.wdata[8];
                scr_bank <= bus.wdata[2];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (io_up && bus.addr[0]) snd_latch <= bus.wdata[7:0];  // Sound code
    end

    //////////////////////////////////////////////////
    // Read data
    always_comb begin
        case (region)
            RAM_R:   bus.rdata = ram_rdata;
            IO_R:    bus.rdata = bus.addr[0] ? {dipsw_b, dipsw_a} :
                                 {coin_input[0], coin_input[1],
                                  start_button[0], start_button[1],
                                  joystick1[3:0], joystick1[4], joystick1[5],
                                  joystick2[3:0], joystick2[4], joystick2[5]};
            SCRL_R: begin
                case (bus.addr[1:0])
                    2'd0:    bus.rdata = scr1_hpos;
                    2'd1:    bus.rdata = scr1_vpos;
                    2'd2:    bus.rdata = {7'd0, scr2_hpos};
                    default: bus.rdata = {7'd0, scr2_vpos};
                endcase
            end
            default: bus.rdata = '1;  // Open bus
        endcase
    end
endmodule

// File: design/bus_arbiter.sv
module bus_arbiter (
    input  logic                clk,
    input  logic                rst,
    // 68000 side
    input  logic                cpu_req,
    input  logic                cpu_we,
    input  main_bus_pkg::be_t   cpu_be,
    input  main_bus_pkg::addr_t cpu_addr,
    input  main_bus_pkg::data_t cpu_wdata,
    output logic                cpu_ack,
    output main_bus_pkg::data_t cpu_rdata,
    // Protection MCU DMA side
    input  logic                mcu_req,
    input  logic                mcu_we,
    input  main_bus_pkg::be_t   mcu_be,
    input  main_bus_pkg::addr_t mcu_addr,
    input  main_bus_pkg::data_t mcu_wdata,
    output logic                mcu_ack,
    output main_bus_pkg::data_t mcu_rdata,
    main_bus_if.master          bus
);
    import main_ctrl_pkg::*;

    arb_state_e state_q;
    arb_state_e state_d;
    logic       own_req;   // Live req of the current owner
    logic       next_req;  // Live req of the owner for next cycle
    logic       bus_free;

    always_comb begin
        case (state_q)
            CPU_OWN: own_req = cpu_req;
            MCU_OWN: own_req = mcu_req;
            default: own_req = 1'b0;
        endcase
    end

    // Four-phase cycle fully unwound on both sides
    assign bus_free = !own_req && !bus.req && !bus.ack;

    always_comb begin
        state_d = state_q;
        if (bus_free) begin
            if (mcu_req)
                state_d = MCU_OWN;  // Bus requests win ties
            else if (cpu_req)
                state_d = CPU_OWN;
            else
                state_d = IDLE;
        end
    end

    assign next_req = (state_d == MCU_OWN) ? mcu_req :
                      (state_d == CPU_OWN) ? cpu_req : 1'b0;

    //////////////////////////////////////////////////
    // Registered request stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            bus.req <= 1'b0;
        end else begin
            state_q <= state_d;
            // A fresh req waits for the slave to drop ack
            bus.req <= next_req && (bus.req || !bus.ack);
        end
    end

    always_ff @(posedge clk) begin
        bus.we    <= (state_d == MCU_OWN) ? mcu_we    : cpu_we;
        bus.be    <= (state_d == MCU_OWN) ? mcu_be    : cpu_be;
        bus.addr  <= (state_d == MCU_OWN) ? mcu_addr  : cpu_addr;
        bus.wdata <= (state_d == MCU_OWN) ? mcu_wdata : cpu_wdata;
    end

    // Masked by bus.req so the owner sees ack fall one cycle after its req
    assign cpu_ack   = (state_q == CPU_OWN) && bus.ack && bus.req;
    assign mcu_ack   = (state_q == MCU_OWN) && bus.ack && bus.req;
    assign cpu_rdata = (state_q == CPU_OWN) ? bus.rdata : '0;
    assign mcu_rdata = (state_q == MCU_OWN) ? bus.rdata : '0;
endmodule

// File: design/main_bus_if.sv
// One four-phase req/ack transaction on the main bus
interface main_bus_if;
    import main_bus_pkg::*;

    // Master to slave, stable while req is high
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;

    // Slave to master
    logic  ack;
    data_t rdata;  // Valid while ack is high

    modport master (
        output req, we, be, addr, wdata,
        input  ack, rdata
    );

    modport slave (
        input  req, we, be, addr, wdata,
        output ack, rdata
    );
endinterface

// File: design/main_ctrl_pkg.sv
package main_ctrl_pkg;

    // Bus ownership
    typedef enum logic [1:0] {
        IDLE,
        CPU_OWN,
        MCU_OWN
    } arb_state_e;

    // Slave side of one access
    typedef enum logic [1:0] {
        WAIT_REQ,
        STRETCH,   // I/O wait running
        ACK_HI
    } acc_state_e;

endpackage

// File: design/main_bus_pkg.sv
`include "main_defines.svh"

package main_bus_pkg;

    typedef logic [`MAIN_AW-1:0] addr_t;      // Word address
    typedef logic [`MAIN_DW-1:0] data_t;
    typedef logic [1:0]          be_t;        // Bit 1 is the upper lane, like UDS
    typedef logic [`RAM_AW-1:0]  ram_addr_t;  // Work RAM word index

    // Top three address bits pick the region
    typedef enum logic [2:0] {
        NONE_R = 3'd0,  // Unmapped, reads back all ones
        SCRL_R = 3'd4,
        IO_R   = 3'd5,
        RAM_R  = 3'd7
    } region_e;

endpackage

// File: design/main_defines.svh
`ifndef MAIN_DEFINES_SVH
`define MAIN_DEFINES_SVH

// Bus geometry
`define MAIN_AW 16  // Word address bits
`define MAIN_DW 16  // Data bits, two byte lanes

// Work RAM depth given as a word index width
`define RAM_AW 10

// Extra cycles an I/O access holds ack low
// Long enough for the sound CPU to catch its NMI
`define IO_WAIT 8

`endif
